// ==== flist.f ====
hdl/mem_pkg.sv
hdl/lsu_req_align.sv
hdl/sync_fifo.sv
hdl/data_ram.sv
hdl/mem_subsys_top.sv
tb/mem_subsys_assert.sv
tb/mem_subsys_tb.sv

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_addr_bits = 6
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  mem_pkg::mem_req_t  req_data,
    output logic               req_ready,
    output logic               resp_valid,
    output mem_pkg::mem_resp_t resp_data,
    input  logic               resp_ready
);
    import mem_pkg::*;

    localparam int words = 2 ** ram_addr_bits;

    logic [xlen-1:0]          mem [words];
    logic [ram_addr_bits-1:0] idx;
    logic                     accept;
    logic                     do_write;
    logic [xlen-1:0]          rd_word;
    logic [xlen-1:0]          rd_lane;
    logic [xlen-1:0]          rd_ext;

    // one response register, stall while it is full and not taken
    assign req_ready = !resp_valid || resp_ready;
    assign accept    = req_valid && req_ready;

    // producer already checked range, keep only the low index bits
    assign idx = req_data.word_idx[ram_addr_bits-1:0];

    // error requests never touch memory
    assign do_write = accept && req_data.wen && !req_data.err;

    // byte lane write, mask selects the lanes
    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < strb_bits; b++) begin
                if (req_data.mask[b]) begin
                    mem[idx][8*b +: 8] <= req_data.wdata[8*b +: 8];
                end
            end
        end
    end

    // read path
    assign rd_word = mem[idx];

    // addressed lane down to bit 0
    assign rd_lane = rd_word >> {req_data.offset, 3'b000};

    // cut to width, then sign or zero extend
    always_comb begin
        case (req_data.width)
            wdt_8: begin
                if (req_data.is_signed) begin
                    rd_ext = {{(xlen-8){rd_lane[7]}}, rd_lane[7:0]};
                end else begin
                    rd_ext = {{(xlen-8){1'b0}}, rd_lane[7:0]};
                end
            end
            wdt_16: begin
                if (req_data.is_signed) begin
                    rd_ext = {{(xlen-16){rd_lane[15]}}, rd_lane[15:0]};
                end else begin
                    rd_ext = {{(xlen-16){1'b0}}, rd_lane[15:0]};
                end
            end
            wdt_32: begin
                if (req_data.is_signed) begin
                    rd_ext = {{(xlen-32){rd_lane[31]}}, rd_lane[31:0]};
                end else begin
                    rd_ext = {{(xlen-32){1'b0}}, rd_lane[31:0]};
                end
            end
            // full word, offset is zero here
            default: begin
                rd_ext = rd_lane;
            end
        endcase
    end

    // response valid, set on accept, cleared when taken
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_data.err      <= req_data.err;
            resp_data.is_write <= req_data.wen;
            // writes and errors answer with zero data
            if (req_data.err || req_data.wen) begin
                resp_data.rdata <= '0;
            end else begin
                resp_data.rdata <= rd_ext;
            end
        end
    end

endmodule

// ==== hdl/lsu_req_align.sv ====
`timescale 1ns/1ps

module lsu_req_align #(
    parameter int          ram_addr_bits = 6,
    parameter logic [63:0] ram_base      = 64'h8000_0000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic [mem_pkg::xlen-1:0] in_addr,
    input  logic                     in_wen,
    input  logic [mem_pkg::xlen-1:0] in_wdata,
    input  mem_pkg::width_op_t       in_width,
    input  logic                     in_signed,
    output logic                     in_ready,
    output logic                     out_valid,
    output mem_pkg::mem_req_t        out_data,
    input  logic                     out_ready
);
    import mem_pkg::*;

    // byte address bits covered by the ram
    localparam int ram_byte_bits = ram_addr_bits + off_bits;

    logic [xlen-1:0]      offs;
    logic                 in_range;
    logic                 aligned;
    logic                 bad;
    logic [strb_bits-1:0] size_mask;
    logic [xlen-1:0]      lane_wdata;
    mem_req_t             req_next;
    logic                 active;
    logic                 take;

    // offset from the start of the ram
    assign offs = in_addr - ram_base;

    // anything above the ram size is out of range
    // addresses below the base wrap to a huge offset and land here too
    assign in_range = (offs[xlen-1:ram_byte_bits] == '0);

    // lane mask and alignment per access size
    always_comb begin
        case (in_width)
            wdt_8: begin
                size_mask = 8'h01;
                aligned   = 1'b1;
            end
            wdt_16: begin
                size_mask = 8'h03;
                aligned   = ~offs[0];
            end
            wdt_32: begin
                size_mask = 8'h0f;
                aligned   = (offs[1:0] == 2'b00);
            end
            default: begin
                size_mask = 8'hff;
                aligned   = (offs[2:0] == 3'b000);
            end
        endcase
    end

    // misaligned accesses are not split, just flagged
    assign bad = !(in_range && aligned);

    // move store data up into its byte lane
    assign lane_wdata = in_wdata << {offs[off_bits-1:0], 3'b000};

    always_comb begin
        req_next.word_idx  = word_idx_t'(offs[ram_byte_bits-1:off_bits]);
        req_next.wen       = in_wen;
        // no lanes enabled on error
        req_next.mask      = bad ? '0 : (size_mask << offs[off_bits-1:0]);
        req_next.wdata     = lane_wdata;
        req_next.offset    = offs[off_bits-1:0];
        req_next.width     = in_width;
        req_next.is_signed = in_signed;
        req_next.err       = bad;
    end

    // ready held low until the first cycle out of reset
    assign in_ready = active && (!out_valid || out_ready);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            // new request wins over drain
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // payload only moves on accept
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= req_next;
        end
    end

endmodule

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // data path width of the core
    localparam int xlen = 64;

    // one strobe bit per byte lane
    localparam int strb_bits = xlen / 8;

    // byte offset inside a 64-bit word
    localparam int off_bits = 3;

    // upper bound for the word index field
    // the ram only looks at its low ram_addr_bits
    localparam int max_word_bits = 16;

    typedef logic [max_word_bits-1:0] word_idx_t;

    // access size, same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        wdt_8  = 2'd0,
        wdt_16 = 2'd1,
        wdt_32 = 2'd2,
        wdt_64 = 2'd3
    } width_op_t;

    // request after address decode
    typedef struct packed {
        word_idx_t            word_idx;
        logic                 wen;
        logic [strb_bits-1:0] mask;
        logic [xlen-1:0]      wdata;
        logic [off_bits-1:0]  offset;
        width_op_t            width;
        logic                 is_signed;
        logic                 err;
    } mem_req_t;

    // response back to the core
    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            err;
        logic            is_write;
    } mem_resp_t;

endpackage

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int          ram_addr_bits = 6,
    parameter logic [63:0] ram_base      = 64'h8000_0000,
    parameter int          fifo_depth    = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    // request channel
    input  logic                     req_valid,
    input  logic [mem_pkg::xlen-1:0] req_addr,
    input  logic                     req_wen,
    input  logic [mem_pkg::xlen-1:0] req_wdata,
    input  mem_pkg::width_op_t       req_width,
    input  logic                     req_signed,
    output logic                     req_ready,
    // response channel
    output logic                     resp_valid,
    output logic [mem_pkg::xlen-1:0] resp_rdata,
    output logic                     resp_err,
    output logic                     resp_is_write,
    input  logic                     resp_ready
);
    import mem_pkg::*;

    // producer to request fifo
    logic      align_valid;
    logic      align_ready;
    mem_req_t  align_data;

    // request fifo to ram
    logic      ram_req_valid;
    logic      ram_req_ready;
    mem_req_t  ram_req_data;

    // ram to response fifo
    logic      ram_resp_valid;
    logic      ram_resp_ready;
    mem_resp_t ram_resp_data;

    // response fifo output payload
    mem_resp_t resp_out;

    // decode, check and lane shift
    lsu_req_align #(
        .ram_addr_bits (ram_addr_bits),
        .ram_base      (ram_base)
    ) lsu_req_align_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_addr   (req_addr),
        .in_wen    (req_wen),
        .in_wdata  (req_wdata),
        .in_width  (req_width),
        .in_signed (req_signed),
        .in_ready  (req_ready),
        .out_valid (align_valid),
        .out_data  (align_data),
        .out_ready (align_ready)
    );

    sync_fifo #(
        .payload_t (mem_req_t),
        .depth     (fifo_depth)
    ) req_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (align_valid),
        .in_data   (align_data),
        .in_ready  (align_ready),
        .out_valid (ram_req_valid),
        .out_data  (ram_req_data),
        .out_ready (ram_req_ready)
    );

    // one cycle ram with masked write
    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) data_ram_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (ram_req_valid),
        .req_data   (ram_req_data),
        .req_ready  (ram_req_ready),
        .resp_valid (ram_resp_valid),
        .resp_data  (ram_resp_data),
        .resp_ready (ram_resp_ready)
    );

    sync_fifo #(
        .payload_t (mem_resp_t),
        .depth     (fifo_depth)
    ) resp_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ram_resp_valid),
        .in_data   (ram_resp_data),
        .in_ready  (ram_resp_ready),
        .out_valid (resp_valid),
        .out_data  (resp_out),
        .out_ready (resp_ready)
    );

    // split response struct onto the ports
    assign resp_rdata    = resp_out.rdata;
    assign resp_err      = resp_out.err;
    assign resp_is_write = resp_out.is_write;

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // depth must be a power of two
    localparam int ptr_bits = $clog2(depth);

    payload_t             mem [depth];
    logic [ptr_bits:0]    wr_ptr;
    logic [ptr_bits:0]    rd_ptr;
    logic [ptr_bits-1:0]  wr_idx;
    logic [ptr_bits-1:0]  rd_idx;
    logic                 full;
    logic                 empty;
    logic                 push;
    logic                 pop;

    assign wr_idx = wr_ptr[ptr_bits-1:0];
    assign rd_idx = rd_ptr[ptr_bits-1:0];

    // same slot, wrap bits differ -> full
    assign full  = (wr_idx == rd_idx) && (wr_ptr[ptr_bits] != rd_ptr[ptr_bits]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_idx];

    // push and pop may happen on the same edge
    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= in_data;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module mem_subsys_tb -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/mem_subsys_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$log"; then
    exit 0
else
    exit 1
fi

// ==== tb/mem_subsys_assert.sv ====
`timescale 1ns/1ps

module mem_subsys_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     req_valid,
    input logic                     req_ready,
    input logic [63:0]              req_addr,
    input logic                     req_wen,
    input logic [63:0]              req_wdata,
    input mem_pkg::width_op_t       req_width,
    input logic                     req_signed,
    input logic                     resp_valid,
    input logic                     resp_ready,
    input logic [63:0]              resp_rdata,
    input logic                     resp_err,
    input logic                     resp_is_write,
    input logic                     fifo_in_valid,
    input mem_pkg::mem_req_t        fifo_in_data,
    input logic                     fifo_full
);

    // request held until taken
    req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid &&
        $stable({req_addr, req_wen, req_wdata, req_width, req_signed}))
        else $error("request dropped or changed before ready");

    // response held until taken
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid &&
        $stable({resp_rdata, resp_err, resp_is_write}))
        else $error("response dropped or changed before ready");

    // nothing offered in the first cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $past(rst) && !rst |-> !req_ready && !resp_valid)
        else $error("output valid high right after reset");

    // request refused by the full request fifo stays offered
    fifo_full_hold: assert property (@(posedge clk) disable iff (rst)
        fifo_full && fifo_in_valid |=> fifo_in_valid && $stable(fifo_in_data))
        else $error("request to full request fifo dropped or changed");

endmodule

bind mem_subsys_top mem_subsys_assert mem_subsys_assert_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_addr      (req_addr),
    .req_wen       (req_wen),
    .req_wdata     (req_wdata),
    .req_width     (req_width),
    .req_signed    (req_signed),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp_rdata    (resp_rdata),
    .resp_err      (resp_err),
    .resp_is_write (resp_is_write),
    .fifo_in_valid (align_valid),
    .fifo_in_data  (align_data),
    .fifo_full     (req_fifo.full)
);

// ==== tb/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int          clk_period = 100;
    localparam logic [63:0] ram_base   = 64'h8000_0000;
    localparam int          ram_bytes  = 512;
    // requests over all five tests
    localparam int          total_reqs = 128 + 120 + 32 + 40 + 32;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [63:0] req_addr;
    logic        req_wen;
    logic [63:0] req_wdata;
    width_op_t   req_width;
    logic        req_signed;
    logic        req_ready;
    logic        resp_valid;
    logic [63:0] resp_rdata;
    logic        resp_err;
    logic        resp_is_write;
    logic        resp_ready;

    // byte image of the ram
    logic [7:0]  ref_mem [ram_bytes];
    // expected {rdata, err, is_write} in request order
    logic [65:0] exp_q [$];

    logic [31:0] stim_lfsr      = 32'h2b35;
    logic [31:0] bp_lfsr        = 32'h2b35;
    int          stall_left     = 0;
    logic        bp_random      = 1'b0;
    logic        saw_drop       = 1'b0;
    int          resp_count     = 0;
    int          check_count    = 0;
    int          err_count      = 0;
    int          test_count     = 0;
    int          test_err_start = 0;

    mem_subsys_top #(
        .ram_addr_bits (6),
        .ram_base      (ram_base),
        .fifo_depth    (4)
    ) mem_subsys_top_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_wen       (req_wen),
        .req_wdata     (req_wdata),
        .req_width     (req_width),
        .req_signed    (req_signed),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_err      (resp_err),
        .resp_is_write (resp_is_write),
        .resp_ready    (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = stim_lfsr[0];
            stim_lfsr = lfsr_next(stim_lfsr);
        end
        return v;
    endfunction

    task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %0d ns: %s mismatch, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // expected response from the byte model
    // model memory updated in request order
    task automatic model_req(input logic [63:0] addr, input logic wen,
                             input logic [63:0] wdata, input width_op_t width,
                             input logic sgn);
        logic [63:0] off;
        logic [63:0] data;
        logic        err;
        int          size;
        off  = addr - ram_base;
        size = 1 << int'(width);
        err  = (off >= ram_bytes) || ((off % size) != 0);
        data = '0;
        if (!err) begin
            for (int i = 0; i < size; i++) begin
                if (wen) begin
                    ref_mem[off + i] = wdata[8*i +: 8];
                end else begin
                    data[8*i +: 8] = ref_mem[off + i];
                end
            end
            // lb lh lw style extension
            if (!wen && sgn && size < 8 && data[8*size-1]) begin
                data = data | (~64'd0 << (8 * size));
            end
        end
        exp_q.push_back({data, err, wen});
    endtask

    // drive after the edge and hold until a ready edge
    // returns on the transfer edge
    task automatic send_req(input logic [63:0] addr, input logic wen,
                            input logic [63:0] wdata, input width_op_t width,
                            input logic sgn);
        logic rdy;
        #1;
        req_valid  = 1'b1;
        req_addr   = addr;
        req_wen    = wen;
        req_wdata  = wdata;
        req_width  = width;
        req_signed = sgn;
        model_req(addr, wen, wdata, width, sgn);
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = req_ready;
            @(posedge clk);
        end
    endtask

    // aligned access of random size, direction and sign
    task automatic rand_access();
        width_op_t   w;
        logic [63:0] off;
        logic        wen;
        logic [63:0] data;
        logic        sgn;
        w    = width_op_t'(2'(rand_bits(2)));
        off  = rand_bits(9) & ~((64'd1 << int'(w)) - 1);
        wen  = 1'(rand_bits(1));
        data = rand_bits(64);
        sgn  = 1'(rand_bits(1));
        send_req(ram_base + off, wen, data, w, sgn);
    endtask

    task automatic wait_drain();
        #1;
        req_valid = 1'b0;
        do @(posedge clk); while (exp_q.size() != 0);
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s finished, %0d errors", name, err_count - test_err_start);
        test_err_start = err_count;
    endtask

    // response ready driven random or stalled
    initial begin
        resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                resp_ready = 1'b0;
                stall_left--;
            end else if (bp_random) begin
                resp_ready = bp_lfsr[0];
                bp_lfsr    = lfsr_next(bp_lfsr);
            end else begin
                resp_ready = 1'b1;
            end
        end
    end

    // mid cycle sample of a transfer on the next rising edge
    always @(negedge clk) begin
        if (!rst && resp_valid && resp_ready) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("unexpected response at %0d ns with no request outstanding", $time);
            end else begin
                check_val({resp_rdata, resp_err, resp_is_write}, exp_q.pop_front(), "response");
            end
        end
        if (stall_left > 0 && req_valid && !req_ready) begin
            saw_drop = 1'b1;
        end
    end

    // hang guard of 40 cycles per request
    initial begin
        #(total_reqs * 40 * clk_period);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 total_reqs * 40);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        width_op_t   w;
        logic [63:0] off;
        logic [63:0] addr;
        logic [1:0]  kind;
        int          start_count;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wen    = 1'b0;
        req_wdata  = '0;
        req_width  = wdt_8;
        req_signed = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);

        // fill every word then read all back
        for (int i = 0; i < 64; i++) begin
            send_req(ram_base + 64'(8 * i), 1'b1, rand_bits(64), wdt_64, 1'b0);
        end
        for (int i = 0; i < 64; i++) begin
            send_req(ram_base + 64'(8 * i), 1'b0, '0, wdt_64, 1'b0);
        end
        wait_drain();
        end_test("fill_readback");

        repeat (120) rand_access();
        wait_drain();
        end_test("random_subword");

        // bad access then a read of the nearby word
        for (int i = 0; i < 16; i++) begin
            kind = 2'(rand_bits(2));
            w    = width_op_t'(2'(rand_bits(2)));
            off  = rand_bits(9);
            case (kind)
                2'd0, 2'd1: begin
                    // bytes are never misaligned
                    if (w == wdt_8) begin
                        w = wdt_64;
                    end
                    addr = ram_base + (off | 64'd1);
                end
                2'd2: addr = ram_base + ram_bytes + off;
                default: addr = ram_base - 64'd8 - off;
            endcase
            send_req(addr, 1'(rand_bits(1)), rand_bits(64), w, 1'(rand_bits(1)));
            send_req(ram_base + (off & ~64'd7), 1'b0, '0, wdt_64, 1'b0);
        end
        wait_drain();
        end_test("error_rules");

        // 20 cycle stall up front then random ready
        bp_random  = 1'b1;
        stall_left = 20;
        saw_drop   = 1'b0;
        repeat (40) rand_access();
        wait_drain();
        bp_random = 1'b0;
        if (!saw_drop) begin
            err_count++;
            $display("req_ready never dropped while responses were stalled");
        end
        end_test("back_pressure");

        start_count = resp_count;
        repeat (32) rand_access();
        wait_drain();
        // quiet window so a stray extra response gets counted
        repeat (8) @(posedge clk);
        check_val(128'(resp_count - start_count), 128'd32, "response count");
        end_test("back_to_back");

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
